/* all.f */
src/pipePkg.sv
src/hazardUnit.sv
src/forwardUnit.sv
src/stageRegs.sv
src/haltControl.sv
src/pipelineControl.sv
testbench/pipelineChecker.sv
testbench/pipelineControlTb.sv

/* build.sh */
#!/usr/bin/env bash
# Build and run the pipeline control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module pipelineControlTb -o pipelineSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/pipelineSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "No errors" <<< "$output"; then
   exit 0
else
   exit 1
fi

/* testbench/pipelineControlTb.sv */
`timescale 1ns/1ns
`default_nettype none

module pipelineControlTb;
   import pipePkg::*;

   logic  clk = 1'b0;
   logic  reset;
   ifIdT  ifIdIn;
   idExT  idExIn;
   exMemT exMemIn;
   memWbT memWbIn;
   logic  fetchStall;
   logic  memStall;
   logic  branchTaken;
   logic  branchUsesRs;
   ifIdT  ifId;
   idExT  idEx;
   exMemT exMem;
   memWbT memWb;
   stallT stall;
   dataT  rsData;
   dataT  rtData;
   dataT  memRtData;
   logic  dmemEn;
   logic  dmemWrite;
   logic  halt;
   logic  err;
   int    errorCount;
   int    checkCount;

   int resetCycles = 10;
   int cyclesPerTest = 300;
   int numTests = 6;

   always #20 clk = ~clk;

   pipelineControl DUT (
      .clk(clk), .reset(reset), .ifIdIn(ifIdIn), .idExIn(idExIn), .exMemIn(exMemIn),
      .memWbIn(memWbIn), .fetchStall(fetchStall), .memStall(memStall),
      .branchTaken(branchTaken), .branchUsesRs(branchUsesRs), .ifId(ifId), .idEx(idEx),
      .exMem(exMem), .memWb(memWb), .stall(stall), .rsData(rsData), .rtData(rtData),
      .memRtData(memRtData), .dmemEn(dmemEn), .dmemWrite(dmemWrite), .halt(halt), .err(err)
   );

   pipelineChecker scoreboard (
      .clk(clk), .reset(reset), .ifIdIn(ifIdIn), .idExIn(idExIn), .exMemIn(exMemIn),
      .memWbIn(memWbIn), .fetchStall(fetchStall), .memStall(memStall),
      .branchTaken(branchTaken), .branchUsesRs(branchUsesRs), .ifId(ifId), .idEx(idEx),
      .exMem(exMem), .memWb(memWb), .stall(stall), .rsData(rsData), .rtData(rtData),
      .memRtData(memRtData), .dmemEn(dmemEn), .dmemWrite(dmemWrite), .halt(halt), .err(err),
      .errorCount(errorCount), .checkCount(checkCount)
   );

   function automatic logic chance(input int pct);
      logic [31:0] r;
      r = $urandom_range(0, 99);
      return int'(r) < pct;
   endfunction

   // Only three registers, so hazards come up often
   function automatic regAddrT smallAddr();
      logic [31:0] r;
      r = $urandom_range(0, 2);
      return r[REG_ADDR_W-1:0];
   endfunction

   function automatic dataT randomWord();
      logic [31:0] r;
      r = $urandom;
      return r[DATA_W-1:0];
   endfunction

   function automatic dataT randomInst();
      dataT inst;
      inst = randomWord();
      inst[RS_MSB:RS_LSB] = smallAddr();
      inst[RT_MSB:RT_LSB] = smallAddr();
      return inst;
   endfunction

   function automatic ctrlT randomCtrl(input int loadPct, input int dumpPct);
      ctrlT c;
      c.regWrite  = chance(70);
      c.dmemWrite = chance(30);
      c.dmemEn    = chance(50);
      c.memToReg  = chance(loadPct);
      c.dmemDump  = chance(dumpPct);
      c.aluSrc2   = chance(50);
      return c;
   endfunction

   task automatic runTest(input string name, input int loadPct, input int branchPct,
                          input int bubblePct, input int memStallPct, input int faultPct);
      int    startErrors;
      int    startChecks;
      ifIdT  f;
      idExT  d;
      exMemT x;
      memWbT w;
      startErrors = errorCount;
      startChecks = checkCount;
      repeat (cyclesPerTest) begin
         f = '{inst: randomInst(), pcPlus2: randomWord(), err: chance(faultPct)};
         d = '{inst: randomInst(), pcPlus2: randomWord(), rsData: randomWord(),
               rtData: randomWord(), rdAddr: smallAddr(),
               ctrl: randomCtrl(loadPct, faultPct), err: chance(faultPct)};
         x = '{aluRes: randomWord(), rtData: randomWord(), rsAddr: smallAddr(),
               rtAddr: smallAddr(), rdAddr: smallAddr(),
               ctrl: randomCtrl(loadPct, faultPct), err: chance(faultPct)};
         w = '{writeData: randomWord(), rdAddr: smallAddr(), regWrite: chance(60),
               dmemDump: chance(faultPct)};
         @(posedge clk);
         ifIdIn       <= f;
         idExIn       <= d;
         exMemIn      <= x;
         memWbIn      <= w;
         fetchStall   <= chance(bubblePct);
         branchTaken  <= chance(bubblePct);
         branchUsesRs <= chance(branchPct);
         memStall     <= chance(memStallPct);
      end
      $display("Test %s: %0d checks, %0d errors", name, checkCount - startChecks,
               errorCount - startErrors);
   endtask

   initial begin
      void'($urandom(42361));
      reset        <= 1'b1;
      ifIdIn       <= '0;
      idExIn       <= '0;
      exMemIn      <= '0;
      memWbIn      <= '0;
      fetchStall   <= 1'b0;
      memStall     <= 1'b0;
      branchTaken  <= 1'b0;
      branchUsesRs <= 1'b0;
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;

      // Faults last, since halt and err stick until reset
      runTest("flow", 0, 0, 20, 0, 0);
      runTest("loadUse", 60, 0, 0, 0, 0);
      runTest("branchHazard", 40, 70, 10, 0, 0);
      runTest("forwarding", 20, 20, 10, 20, 0);
      runTest("memStall", 30, 30, 10, 60, 0);
      runTest("haltError", 20, 20, 10, 10, 3);

      @(negedge clk);
      #1;
      $display("Total: %0d checks, %0d errors", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin : watchdog
      int limitNs;
      limitNs = (resetCycles + numTests * cyclesPerTest + 50) * 40;
      #(limitNs);
      $display("Timeout: the tests did not finish in the expected time");
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/pipelineChecker.sv */
`timescale 1ns/1ns
`default_nettype none

module pipelineChecker (
   input  logic           clk,
   input  logic           reset,
   input  pipePkg::ifIdT  ifIdIn,
   input  pipePkg::idExT  idExIn,
   input  pipePkg::exMemT exMemIn,
   input  pipePkg::memWbT memWbIn,
   input  logic           fetchStall,
   input  logic           memStall,
   input  logic           branchTaken,
   input  logic           branchUsesRs,
   input  pipePkg::ifIdT  ifId,
   input  pipePkg::idExT  idEx,
   input  pipePkg::exMemT exMem,
   input  pipePkg::memWbT memWb,
   input  pipePkg::stallT stall,
   input  pipePkg::dataT  rsData,
   input  pipePkg::dataT  rtData,
   input  pipePkg::dataT  memRtData,
   input  logic           dmemEn,
   input  logic           dmemWrite,
   input  logic           halt,
   input  logic           err,
   output int             errorCount,
   output int             checkCount
);
   import pipePkg::*;

   // Model state of the core
   ifIdT  mIfId;
   idExT  mIdEx;
   exMemT mExMem;
   memWbT mMemWb;
   logic  mHalt;
   logic  mErr;

   function automatic logic writesBack(input regAddrT src);
      return mMemWb.regWrite & (mMemWb.rdAddr == src);
   endfunction

   // Non-load result in EX/MEM first, then write-back data
   function automatic dataT forwarded(input regAddrT src, input dataT regData);
      if (mExMem.ctrl.regWrite && !mExMem.ctrl.memToReg && mExMem.rdAddr == src) begin
         return mExMem.aluRes;
      end
      if (writesBack(src)) begin
         return mMemWb.writeData;
      end
      return regData;
   endfunction

   task automatic compareValue(input string name, input logic [79:0] got,
                               input logic [79:0] expected);
      checkCount = checkCount + 1;
      if (got !== expected) begin
         errorCount = errorCount + 1;
         $display("Fail %s at %0t ns: got %0h, expected %0h", name, $time, got, expected);
      end
   endtask

   // Inputs and outputs are settled at the falling edge
   always @(negedge clk) begin : step
      regAddrT branchRs;
      regAddrT exRs;
      regAddrT exRt;
      logic    load;
      logic    decodeStall;
      logic    executeStall;
      stallT   expStall;
      ifIdT    nIfId;
      idExT    nIdEx;
      exMemT   nExMem;
      memWbT   nMemWb;
      if (reset) begin
         mIfId      = '0;
         mIdEx      = '0;
         mExMem     = '0;
         mMemWb     = '0;
         mHalt      = 1'b0;
         mErr       = 1'b0;
         errorCount = 0;
         checkCount = 0;
      end else begin
         branchRs = mIfId.inst[RS_MSB:RS_LSB];
         exRs     = mIdEx.inst[RS_MSB:RS_LSB];
         exRt     = mIdEx.inst[RT_MSB:RT_LSB];
         load     = mExMem.ctrl.regWrite & mExMem.ctrl.memToReg;
         decodeStall = branchUsesRs &
            ((mIdEx.ctrl.regWrite & (mIdEx.rdAddr == branchRs)) |
             (load & (mExMem.rdAddr == branchRs)));
         executeStall = load & ((mExMem.rdAddr == exRs) |
            (mIdEx.ctrl.aluSrc2 & (mExMem.rdAddr == exRt)));

         expStall.ifIdHold    = memStall | executeStall | decodeStall;
         expStall.idExHold    = memStall | executeStall;
         expStall.exMemHold   = memStall;
         expStall.ifIdBubble  = branchTaken | fetchStall;
         expStall.idExBubble  = decodeStall;
         expStall.exMemBubble = executeStall;
         expStall.memWbBubble = memStall;

         compareValue("ifId", 80'(ifId), 80'(mIfId));
         compareValue("idEx", 80'(idEx), 80'(mIdEx));
         compareValue("exMem", 80'(exMem), 80'(mExMem));
         compareValue("memWb", 80'(memWb), 80'(mMemWb));
         compareValue("stall", 80'(stall), 80'(expStall));
         compareValue("rsData", 80'(rsData), 80'(forwarded(exRs, mIdEx.rsData)));
         compareValue("rtData", 80'(rtData), 80'(forwarded(exRt, mIdEx.rtData)));
         compareValue("memRtData", 80'(memRtData),
            80'(writesBack(mExMem.rtAddr) ? mMemWb.writeData : mExMem.rtData));
         compareValue("dmemEn", 80'(dmemEn), 80'(mExMem.ctrl.dmemEn & ~mHalt & ~mErr));
         compareValue("dmemWrite", 80'(dmemWrite),
            80'(mExMem.ctrl.dmemWrite & ~mHalt & ~mErr));
         compareValue("halt", 80'(halt), 80'(mHalt));
         compareValue("err", 80'(err), 80'(mErr));

         nIfId = mIfId;
         if (!expStall.ifIdHold) begin
            nIfId = ifIdIn;
            if (expStall.ifIdBubble) begin
               nIfId.inst = NOP_INST;
               nIfId.err  = 1'b0;
            end
         end

         nIdEx = mIdEx;
         if (!expStall.idExHold) begin
            nIdEx     = idExIn;
            nIdEx.err = idExIn.err | mIfId.err;
            if (expStall.idExBubble) begin
               nIdEx.ctrl = '0;
               nIdEx.err  = 1'b0;
            end
         end else begin
            if (writesBack(exRs)) begin
               nIdEx.rsData = mMemWb.writeData;
            end
            if (writesBack(exRt)) begin
               nIdEx.rtData = mMemWb.writeData;
            end
         end

         nExMem = mExMem;
         if (!expStall.exMemHold) begin
            nExMem     = exMemIn;
            nExMem.err = exMemIn.err | mIdEx.err;
            if (expStall.exMemBubble) begin
               nExMem.ctrl = '0;
               nExMem.err  = 1'b0;
            end
         end else if (writesBack(mExMem.rtAddr)) begin
            nExMem.rtData = mMemWb.writeData;
         end

         nMemWb          = memWbIn;
         nMemWb.regWrite = memWbIn.regWrite & ~mExMem.err & ~mErr;
         if (expStall.memWbBubble) begin
            nMemWb.regWrite = 1'b0;
            nMemWb.dmemDump = 1'b0;
         end

         mHalt  = mHalt | mExMem.ctrl.dmemDump | mExMem.err;
         mErr   = mErr | mExMem.err;
         mIfId  = nIfId;
         mIdEx  = nIdEx;
         mExMem = nExMem;
         mMemWb = nMemWb;
      end
   end

endmodule

`default_nettype wire

/* src/pipelineControl.sv */
`timescale 1ns/1ns
`default_nettype none

module pipelineControl (
   input  logic           clk,
   input  logic           reset,
   input  pipePkg::ifIdT  ifIdIn,
   input  pipePkg::idExT  idExIn,
   input  pipePkg::exMemT exMemIn,
   input  pipePkg::memWbT memWbIn,
   input  logic           fetchStall,
   input  logic           memStall,
   input  logic           branchTaken,
   input  logic           branchUsesRs,
   output pipePkg::ifIdT  ifId,
   output pipePkg::idExT  idEx,
   output pipePkg::exMemT exMem,
   output pipePkg::memWbT memWb,
   output pipePkg::stallT stall,
   output pipePkg::dataT  rsData,
   output pipePkg::dataT  rtData,
   output pipePkg::dataT  memRtData,
   output logic           dmemEn,
   output logic           dmemWrite,
   output logic           halt,
   output logic           err
);
   import pipePkg::*;

   dataT captureData;
   logic rsCapture;
   logic rtCapture;
   logic rtMemCapture;
   logic memWbRegWrite;

   hazardUnit hazard (
      .ifId         (ifId),
      .idEx         (idEx),
      .exMem        (exMem),
      .fetchStall   (fetchStall),
      .memStall     (memStall),
      .branchTaken  (branchTaken),
      .branchUsesRs (branchUsesRs),
      .stall        (stall)
   );

   forwardUnit forward (
      .idEx         (idEx),
      .exMem        (exMem),
      .memWb        (memWb),
      .stall        (stall),
      .rsSel        (),
      .rtSel        (),
      .rsData       (rsData),
      .rtData       (rtData),
      .memRtData    (memRtData),
      .captureData  (captureData),
      .rsCapture    (rsCapture),
      .rtCapture    (rtCapture),
      .rtMemCapture (rtMemCapture)
   );

   stageRegs regs (
      .clk           (clk),
      .reset         (reset),
      .ifIdIn        (ifIdIn),
      .idExIn        (idExIn),
      .exMemIn       (exMemIn),
      .memWbIn       (memWbIn),
      .memWbRegWrite (memWbRegWrite),
      .stall         (stall),
      .rsCapture     (rsCapture),
      .rtCapture     (rtCapture),
      .rtMemCapture  (rtMemCapture),
      .captureData   (captureData),
      .ifId          (ifId),
      .idEx          (idEx),
      .exMem         (exMem),
      .memWb         (memWb)
   );

   haltControl haltCtl (
      .clk           (clk),
      .reset         (reset),
      .exMem         (exMem),
      .memWbIn       (memWbIn),
      .halt          (halt),
      .err           (err),
      .errNext       (),
      .dmemEn        (dmemEn),
      .dmemWrite     (dmemWrite),
      .memWbRegWrite (memWbRegWrite)
   );

endmodule

`default_nettype wire

/* src/haltControl.sv */
`timescale 1ns/1ns
`default_nettype none

module haltControl (
   input  logic           clk,
   input  logic           reset,
   input  pipePkg::exMemT exMem,
   input  pipePkg::memWbT memWbIn,
   output logic           halt,
   output logic           err,
   output logic           errNext,
   output logic           dmemEn,
   output logic           dmemWrite,
   output logic           memWbRegWrite
);

   logic haltNext;

   assign errNext  = exMem.err;
   assign haltNext = exMem.ctrl.dmemDump | errNext;

   // Both latches stick until reset
   always_ff @(posedge clk) begin
      if (reset) begin
         halt <= 1'b0;
         err  <= 1'b0;
      end else begin
         halt <= halt | haltNext;
         err  <= err | errNext;
      end
   end

   assign dmemEn    = exMem.ctrl.dmemEn & ~halt & ~err;
   assign dmemWrite = exMem.ctrl.dmemWrite & ~halt & ~err;

   // No register write-back from a faulting instruction or after one
   assign memWbRegWrite = memWbIn.regWrite & ~errNext & ~err;

endmodule

`default_nettype wire

/* src/stageRegs.sv */
`timescale 1ns/1ns
`default_nettype none

module stageRegs (
   input  logic           clk,
   input  logic           reset,
   input  pipePkg::ifIdT  ifIdIn,
   input  pipePkg::idExT  idExIn,
   input  pipePkg::exMemT exMemIn,
   input  pipePkg::memWbT memWbIn,
   input  logic           memWbRegWrite,
   input  pipePkg::stallT stall,
   input  logic           rsCapture,
   input  logic           rtCapture,
   input  logic           rtMemCapture,
   input  pipePkg::dataT  captureData,
   output pipePkg::ifIdT  ifId,
   output pipePkg::idExT  idEx,
   output pipePkg::exMemT exMem,
   output pipePkg::memWbT memWb
);
   import pipePkg::*;

   ifIdT  ifIdNext;
   idExT  idExNext;
   exMemT exMemNext;
   memWbT memWbNext;

   always_comb begin
      ifIdNext = ifIdIn;
      if (stall.ifIdBubble) begin
         ifIdNext.inst = NOP_INST;
         ifIdNext.err  = 1'b0;
      end
   end

   // Error bit follows the instruction down the pipe
   always_comb begin
      idExNext     = idExIn;
      idExNext.err = idExIn.err | ifId.err;
      if (stall.idExBubble) begin
         idExNext.ctrl = '0;
         idExNext.err  = 1'b0;
      end
   end

   always_comb begin
      exMemNext     = exMemIn;
      exMemNext.err = exMemIn.err | idEx.err;
      if (stall.exMemBubble) begin
         exMemNext.ctrl = '0;
         exMemNext.err  = 1'b0;
      end
   end

   always_comb begin
      memWbNext          = memWbIn;
      memWbNext.regWrite = memWbRegWrite;
      if (stall.memWbBubble) begin
         memWbNext.regWrite = 1'b0;
         memWbNext.dmemDump = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ifId  <= '0;
         idEx  <= '0;
         exMem <= '0;
         memWb <= '0;
      end else begin
         if (!stall.ifIdHold) begin
            ifId <= ifIdNext;
         end

         if (!stall.idExHold) begin
            idEx <= idExNext;
         end else begin
            // Operand fields still take write-back data while held
            if (rsCapture) begin
               idEx.rsData <= captureData;
            end
            if (rtCapture) begin
               idEx.rtData <= captureData;
            end
         end

         if (!stall.exMemHold) begin
            exMem <= exMemNext;
         end else if (rtMemCapture) begin
            exMem.rtData <= captureData;
         end

         memWb <= memWbNext;
      end
   end

endmodule

`default_nettype wire

/* src/forwardUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module forwardUnit (
   input  pipePkg::idExT   idEx,
   input  pipePkg::exMemT  exMem,
   input  pipePkg::memWbT  memWb,
   input  pipePkg::stallT  stall,
   output pipePkg::fwdSelT rsSel,
   output pipePkg::fwdSelT rtSel,
   output pipePkg::dataT   rsData,
   output pipePkg::dataT   rtData,
   output pipePkg::dataT   memRtData,
   output pipePkg::dataT   captureData,
   output logic            rsCapture,
   output logic            rtCapture,
   output logic            rtMemCapture
);
   import pipePkg::*;

   logic wbRsMatch;
   logic wbRtMatch;
   logic wbMemRtMatch;

   function automatic logic wbMatch(input regAddrT src);
      return (src == memWb.rdAddr) & memWb.regWrite;
   endfunction

   // EX/MEM wins over MEM/WB, loads in EX/MEM are not ready yet
   function automatic fwdSelT pickSource(input regAddrT src);
      fwdSelT sel;
      if ((src == exMem.rdAddr) & exMem.ctrl.regWrite & ~exMem.ctrl.memToReg) begin
         sel = FWD_EX;
      end else if (wbMatch(src)) begin
         sel = FWD_MEM;
      end else begin
         sel = FWD_NONE;
      end
      return sel;
   endfunction

   function automatic dataT operand(input fwdSelT sel, input dataT regData);
      dataT value;
      case (sel)
         FWD_EX:  value = exMem.aluRes;
         FWD_MEM: value = memWb.writeData;
         default: value = regData;
      endcase
      return value;
   endfunction

   assign rsSel  = pickSource(idEx.inst[RS_MSB:RS_LSB]);
   assign rtSel  = pickSource(idEx.inst[RT_MSB:RT_LSB]);
   assign rsData = operand(rsSel, idEx.rsData);
   assign rtData = operand(rtSel, idEx.rtData);

   // Store data in memory stage
   assign wbMemRtMatch = wbMatch(exMem.rtAddr);
   assign memRtData    = wbMemRtMatch ? memWb.writeData : exMem.rtData;

   // Held stages grab the write-back value before it leaves the pipe
   assign wbRsMatch    = wbMatch(idEx.inst[RS_MSB:RS_LSB]);
   assign wbRtMatch    = wbMatch(idEx.inst[RT_MSB:RT_LSB]);
   assign rsCapture    = stall.idExHold & wbRsMatch;
   assign rtCapture    = stall.idExHold & wbRtMatch;
   assign rtMemCapture = stall.exMemHold & wbMemRtMatch;
   assign captureData  = memWb.writeData;

endmodule

`default_nettype wire

/* src/hazardUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
   input  pipePkg::ifIdT  ifId,
   input  pipePkg::idExT  idEx,
   input  pipePkg::exMemT exMem,
   input  logic           fetchStall,
   input  logic           memStall,
   input  logic           branchTaken,
   input  logic           branchUsesRs,
   output pipePkg::stallT stall
);
   import pipePkg::*;

   regAddrT branchRs;
   regAddrT exRs;
   regAddrT exRt;
   logic    exMemLoad;
   logic    decodeStall;
   logic    executeStall;

   assign branchRs = ifId.inst[RS_MSB:RS_LSB];
   assign exRs     = idEx.inst[RS_MSB:RS_LSB];
   assign exRt     = idEx.inst[RT_MSB:RT_LSB];

   assign exMemLoad = exMem.ctrl.regWrite & exMem.ctrl.memToReg;

   // Branch rs still in flight, either in execute or as a load in memory
   assign decodeStall = branchUsesRs &
      (((branchRs == idEx.rdAddr) & idEx.ctrl.regWrite) |
       ((branchRs == exMem.rdAddr) & exMemLoad));

   // Load-use on an execute operand
   assign executeStall = exMemLoad &
      ((exRs == exMem.rdAddr) |
       ((exRt == exMem.rdAddr) & idEx.ctrl.aluSrc2));

   always_comb begin
      stall.ifIdHold    = decodeStall | executeStall | memStall;
      stall.idExHold    = executeStall | memStall;
      stall.exMemHold   = memStall;
      stall.ifIdBubble  = branchTaken | fetchStall;
      stall.idExBubble  = decodeStall;
      stall.exMemBubble = executeStall;
      stall.memWbBubble = memStall;
   end

endmodule

`default_nettype wire

/* src/pipePkg.sv */
`default_nettype none

package pipePkg;

   localparam int DATA_W = 16;
   localparam int REG_ADDR_W = 3;

   // Source register fields of an instruction
   localparam int RS_MSB = 10;
   localparam int RS_LSB = 8;
   localparam int RT_MSB = 7;
   localparam int RT_LSB = 5;

   typedef logic [DATA_W-1:0] dataT;
   typedef logic [REG_ADDR_W-1:0] regAddrT;

   localparam dataT NOP_INST = 16'h0800;

   typedef struct packed {
      logic regWrite;
      logic dmemWrite;
      logic dmemEn;
      logic memToReg;
      logic dmemDump;
      logic aluSrc2;
   } ctrlT;

   typedef struct packed {
      dataT inst;
      dataT pcPlus2;
      logic err;
   } ifIdT;

   typedef struct packed {
      dataT    inst;
      dataT    pcPlus2;
      dataT    rsData;
      dataT    rtData;
      regAddrT rdAddr;
      ctrlT    ctrl;
      logic    err;
   } idExT;

   typedef struct packed {
      dataT    aluRes;
      dataT    rtData;
      regAddrT rsAddr;
      regAddrT rtAddr;
      regAddrT rdAddr;
      ctrlT    ctrl;
      logic    err;
   } exMemT;

   typedef struct packed {
      dataT    writeData;
      regAddrT rdAddr;
      logic    regWrite;
      logic    dmemDump;
   } memWbT;

   typedef enum logic [1:0] {
      FWD_NONE,
      FWD_EX,
      FWD_MEM
   } fwdSelT;

   typedef struct packed {
      logic ifIdHold;
      logic idExHold;
      logic exMemHold;
      logic ifIdBubble;
      logic idExBubble;
      logic exMemBubble;
      logic memWbBubble;
   } stallT;

endpackage

`default_nettype wire
